// File: tests/ddr_testdata.txt
// columns: ready delay _ stall percent _ corrupt index _ corrupt xor mask _ bad write resp index
//          _ bad read resp index _ expected mismatch_count _ expected resp_err_count (hex, FF = none)
04_00_FF_00000000_FF_FF_00_00
02_00_03_00000100_FF_FF_01_00
01_00_FF_00000000_05_FF_00_01
00_00_FF_00000000_FF_06_00_01
06_46_FF_00000000_FF_FF_00_00
03_00_07_80000000_00_02_01_02
03_46_07_80000000_00_02_01_02

// File: build.f
logic/ddr_test_pkg.sv
logic/rd_beat_if.sv
logic/axi_wr_engine.sv
logic/axi_rd_engine.sv
logic/readback_checker.sv
logic/ddr_test_top.sv
tests/ddr_test_monitor.sv
tests/tb_ddr_test.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
mkdir -p build
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -j 0 \
    --top-module tb_ddr_test -Mdir build/obj -f build.f \
    && ./build/obj/Vtb_ddr_test > build/sim.log 2>&1 \
    || { cat build/sim.log 2>/dev/null; echo "compile or run error"; exit 1; }
cat build/sim.log
grep -qx "test passed" build/sim.log \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

// File: tests/tb_ddr_test.sv
module tb_ddr_test;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          DATA_WIDTH     = 128;
    localparam int          NUM_WORDS      = 8;
    localparam logic [31:0] BASE_ADDR      = 32'h8000_0000;
    localparam int          WORD_BYTES     = DATA_WIDTH / 8;
    localparam int          NUM_TESTS      = 7;
    localparam int          READ_DELAY     = 3;
    localparam int          TIMEOUT_CYCLES = NUM_TESTS * (NUM_WORDS * 40 + 100);

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  ddr_ready;
    logic [31:0]           awaddr;
    logic                  awvalid;
    logic                  awready = 1'b0;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  wvalid;
    logic                  wready = 1'b0;
    logic                  bvalid = 1'b0;
    logic [1:0]            bresp = 2'b00;
    logic [31:0]           araddr;
    logic                  arvalid;
    logic                  arready = 1'b0;
    logic [DATA_WIDTH-1:0] rdata = '0;
    logic                  rvalid = 1'b0;
    logic [1:0]            rresp = 2'b00;
    logic                  test_done;
    logic                  test_pass;
    logic [15:0]           mismatch_count;
    logic [15:0]           resp_err_count;

    logic [87:0]           test_vec [0:NUM_TESTS-1];
    logic [87:0]           cur_test = '0;
    logic [7:0]            stall_pct;
    logic [7:0]            corrupt_idx;
    logic [31:0]           corrupt_mask;
    logic [7:0]            bad_wr_idx;
    logic [7:0]            bad_rd_idx;
    int                    test_num = 0;
    int                    cyc = 0;
    int                    seed = 70117;
    int                    error_count;
    int                    tests_checked;

    // slave model state.
    logic [DATA_WIDTH-1:0] mem [0:NUM_WORDS-1];
    logic [DATA_WIDTH-1:0] wr_word;
    logic [DATA_WIDTH-1:0] rd_word;
    int                    wr_slot;
    int                    slot;
    int                    b_num;
    int                    i;
    bit                    have_aw;
    bit                    have_w;
    bit                    resp_pending;
    int                    rd_due[$];
    int                    rd_slot[$];

    assign stall_pct    = cur_test[79:72];
    assign corrupt_idx  = cur_test[71:64];
    assign corrupt_mask = cur_test[63:32];
    assign bad_wr_idx   = cur_test[31:24];
    assign bad_rd_idx   = cur_test[23:16];

    always #50 clk = ~clk;

    ddr_test_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_WORDS  (NUM_WORDS),
        .BASE_ADDR  (BASE_ADDR)
    ) u_ddr_test_top (
        .clk            (clk),
        .rstn           (rstn),
        .ddr_ready      (ddr_ready),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wvalid         (wvalid),
        .wready         (wready),
        .bvalid         (bvalid),
        .bresp          (bresp),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rvalid         (rvalid),
        .rresp          (rresp),
        .test_done      (test_done),
        .test_pass      (test_pass),
        .mismatch_count (mismatch_count),
        .resp_err_count (resp_err_count)
    );

    ddr_test_monitor #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_WORDS  (NUM_WORDS),
        .BASE_ADDR  (BASE_ADDR)
    ) u_monitor (
        .clk            (clk),
        .rstn           (rstn),
        .ddr_ready      (ddr_ready),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wvalid         (wvalid),
        .wready         (wready),
        .bvalid         (bvalid),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .test_done      (test_done),
        .test_pass      (test_pass),
        .mismatch_count (mismatch_count),
        .resp_err_count (resp_err_count),
        .test_num       (test_num),
        .exp_mismatch   (cur_test[15:8]),
        .exp_resp_err   (cur_test[7:0]),
        .error_count    (error_count),
        .tests_checked  (tests_checked)
    );

    function automatic logic accept_now();
        return ($unsigned($random(seed)) % 100) >= stall_pct;
    endfunction

    function automatic int addr_to_slot(input logic [31:0] addr);
        return int'((addr - BASE_ADDR) / WORD_BYTES);
    endfunction

    // AXI slave with single-beat writes and in-order reads after a fixed delay.
    always @(posedge clk) begin
        if (!rstn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            have_aw      = 1'b0;
            have_w       = 1'b0;
            resp_pending = 1'b0;
            b_num        = 0;
            rd_due.delete();
            rd_slot.delete();
            for (i = 0; i < NUM_WORDS; i++) begin
                mem[i] = {(DATA_WIDTH / 32){32'hDEAD_0000 ^ i}};
            end
        end else begin
            awready <= accept_now();
            wready  <= accept_now();
            arready <= accept_now();
            if (awvalid && awready) begin
                wr_slot = addr_to_slot(awaddr);
                have_aw = 1'b1;
            end
            if (wvalid && wready) begin
                wr_word = wdata;
                have_w  = 1'b1;
            end
            if (have_aw && have_w) begin
                if (wr_slot >= 0 && wr_slot < NUM_WORDS) begin
                    mem[wr_slot] = wr_word;
                end
                have_aw      = 1'b0;
                have_w       = 1'b0;
                resp_pending = 1'b1;
            end
            if (bvalid) begin
                bvalid <= 1'b0;
            end else if (resp_pending && accept_now()) begin
                bvalid       <= 1'b1;
                bresp        <= (b_num == int'(bad_wr_idx)) ? 2'b10 : 2'b00;
                b_num        = b_num + 1;
                resp_pending = 1'b0;
            end
            if (arvalid && arready) begin
                rd_due.push_back(cyc + READ_DELAY);
                rd_slot.push_back(addr_to_slot(araddr));
            end
            rvalid <= 1'b0;
            if (rd_due.size() > 0 && rd_due[0] <= cyc) begin
                slot = rd_slot[0];
                rd_due.delete(0);
                rd_slot.delete(0);
                rd_word = (slot >= 0 && slot < NUM_WORDS) ? mem[slot] : '0;
                if (slot == int'(corrupt_idx)) begin
                    rd_word[31:0] = rd_word[31:0] ^ corrupt_mask;
                end
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= (slot == int'(bad_rd_idx)) ? 2'b10 : 2'b00;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles before all tests finished", cyc);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int t;
        rstn      = 1'b0;
        ddr_ready = 1'b0;
        $readmemh("tests/ddr_testdata.txt", test_vec);
        for (t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk);
            rstn      <= 1'b0;
            ddr_ready <= 1'b0;
            cur_test  <= test_vec[t];
            test_num  <= t;
            repeat (3) @(posedge clk);
            rstn <= 1'b1;
            repeat (test_vec[t][87:80]) @(posedge clk);
            ddr_ready <= 1'b1;
            while (!test_done) @(posedge clk);
            repeat (2) @(posedge clk);
        end
        $display("%0d of %0d tests checked, %0d errors", tests_checked, NUM_TESTS, error_count);
        if (error_count == 0 && tests_checked == NUM_TESTS) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tests/ddr_test_monitor.sv
module ddr_test_monitor #(
    parameter int          DATA_WIDTH = 128,
    parameter int          NUM_WORDS  = 8,
    parameter logic [31:0] BASE_ADDR  = 32'h0
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ddr_ready,
    input  logic [31:0]           awaddr,
    input  logic                  awvalid,
    input  logic                  awready,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    input  logic [31:0]           araddr,
    input  logic                  arvalid,
    input  logic                  arready,
    input  logic                  test_done,
    input  logic                  test_pass,
    input  logic [15:0]           mismatch_count,
    input  logic [15:0]           resp_err_count,
    input  int                    test_num,
    input  logic [7:0]            exp_mismatch,
    input  logic [7:0]            exp_resp_err,
    output int                    error_count,
    output int                    tests_checked
);
    timeunit 1ns;
    timeprecision 1ps;

    int errors = 0;
    int checked = 0;
    int errors_at_start = 0;
    int aw_cnt;
    int w_cnt;
    int b_cnt;
    int ar_cnt;
    bit ready_seen;
    bit done_seen;

    assign error_count   = errors;
    assign tests_checked = checked;

    // every 32-bit lane is {word index, lane number} xor the fixed key.
    function automatic logic [DATA_WIDTH-1:0] expected_word(input int idx);
        logic [DATA_WIDTH-1:0] word;
        int lane;
        word = '0;
        for (lane = 0; lane < DATA_WIDTH / 32; lane++) begin
            word[lane*32 +: 32] = {idx[15:0], lane[15:0]} ^ 32'h5A3C_96E1;
        end
        return word;
    endfunction

    function automatic logic [31:0] word_addr(input int idx);
        return BASE_ADDR + 32'(idx * (DATA_WIDTH / 8));
    endfunction

    task automatic note_bad_value(input string name, input logic [DATA_WIDTH-1:0] got,
                                  input logic [DATA_WIDTH-1:0] want);
        $display("Mismatch %s in test %0d: got 0x%0h, expected 0x%0h", name, test_num, got, want);
        errors++;
    endtask

    task automatic note_bad_event(input string what);
        $display("Error in test %0d: %s", test_num, what);
        errors++;
    endtask

    task automatic check_results();
        logic exp_pass;
        exp_pass = (exp_mismatch == 8'd0) && (exp_resp_err == 8'd0);
        if (mismatch_count !== 16'(exp_mismatch)) begin
            note_bad_value("mismatch_count", mismatch_count, exp_mismatch);
        end
        if (resp_err_count !== 16'(exp_resp_err)) begin
            note_bad_value("resp_err_count", resp_err_count, exp_resp_err);
        end
        if (test_pass !== exp_pass) begin
            note_bad_value("test_pass", test_pass, exp_pass);
        end
        if (aw_cnt != NUM_WORDS || w_cnt != NUM_WORDS || b_cnt != NUM_WORDS) begin
            note_bad_event("the block was not written exactly once before test_done");
        end
        if (ar_cnt != NUM_WORDS) begin
            note_bad_event("the number of read addresses differs from the block size");
        end
        checked++;
        $display("test %0d finished: mismatch_count=%0d resp_err_count=%0d test_pass=%0b, %0d errors",
                 test_num, mismatch_count, resp_err_count, test_pass, errors - errors_at_start);
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            aw_cnt          = 0;
            w_cnt           = 0;
            b_cnt           = 0;
            ar_cnt          = 0;
            ready_seen      = 1'b0;
            done_seen       = 1'b0;
            errors_at_start = errors;
        end else begin
            if (!ready_seen && (awvalid || wvalid || arvalid || test_done)) begin
                note_bad_event("a valid or test_done went high before ddr_ready");
            end
            if (ddr_ready) begin
                ready_seen = 1'b1;
            end
            if (awvalid && awready) begin
                if (aw_cnt >= NUM_WORDS) begin
                    note_bad_event("more write addresses than words in the block");
                end else if (awaddr !== word_addr(aw_cnt)) begin
                    note_bad_value("awaddr", awaddr, word_addr(aw_cnt));
                end
                aw_cnt++;
            end
            if (wvalid && wready) begin
                if (w_cnt < NUM_WORDS && wdata !== expected_word(w_cnt)) begin
                    note_bad_value("wdata", wdata, expected_word(w_cnt));
                end
                w_cnt++;
            end
            if (bvalid) begin
                b_cnt++;
            end
            if (arvalid && arready) begin
                if (b_cnt != NUM_WORDS) begin
                    note_bad_event("a read address was accepted before the last write response");
                end
                if (araddr !== word_addr(ar_cnt)) begin
                    note_bad_value("araddr", araddr, word_addr(ar_cnt));
                end
                ar_cnt++;
            end
            if (test_done && !done_seen) begin
                done_seen = 1'b1;
                check_results();
            end
        end
    end

endmodule

// File: logic/ddr_test_top.sv
module ddr_test_top #(
    parameter int                      DATA_WIDTH = 128,
    parameter int                      NUM_WORDS  = 8,
    parameter ddr_test_pkg::axi_addr_t BASE_ADDR  = 32'h4000_0000
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    ddr_ready,

    output ddr_test_pkg::axi_addr_t awaddr,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [DATA_WIDTH-1:0]   wdata,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    input  ddr_test_pkg::axi_resp_t bresp,

    output ddr_test_pkg::axi_addr_t araddr,
    output logic                    arvalid,
    input  logic                    arready,
    input  logic [DATA_WIDTH-1:0]   rdata,
    input  logic                    rvalid,
    input  ddr_test_pkg::axi_resp_t rresp,

    output logic                    test_done,
    output logic                    test_pass,
    output ddr_test_pkg::word_idx_t mismatch_count,
    output ddr_test_pkg::word_idx_t resp_err_count
);
    import ddr_test_pkg::*;

    logic      wr_done;
    word_idx_t wr_err_count;

    rd_beat_if #(.DATA_WIDTH(DATA_WIDTH)) beats ();

    axi_wr_engine #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_WORDS  (NUM_WORDS),
        .BASE_ADDR  (BASE_ADDR)
    ) u_wr_engine (
        .clk          (clk),
        .rstn         (rstn),
        .ddr_ready    (ddr_ready),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bresp        (bresp),
        .wr_done      (wr_done),
        .wr_err_count (wr_err_count)
    );

    axi_rd_engine #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_WORDS  (NUM_WORDS),
        .BASE_ADDR  (BASE_ADDR)
    ) u_rd_engine (
        .clk       (clk),
        .rstn      (rstn),
        .ddr_ready (ddr_ready),
        .wr_done   (wr_done),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .rresp     (rresp),
        .beats     (beats.src)
    );

    readback_checker #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_checker (
        .clk            (clk),
        .rstn           (rstn),
        .beats          (beats.snk),
        .wr_done        (wr_done),
        .wr_err_count   (wr_err_count),
        .test_done      (test_done),
        .test_pass      (test_pass),
        .mismatch_count (mismatch_count),
        .resp_err_count (resp_err_count)
    );

endmodule

// File: logic/readback_checker.sv
module readback_checker #(
    parameter int DATA_WIDTH = 128
) (
    input  logic                    clk,
    input  logic                    rstn,
    rd_beat_if.snk                  beats,
    input  logic                    wr_done,
    input  ddr_test_pkg::word_idx_t wr_err_count,
    output logic                    test_done,
    output logic                    test_pass,
    output ddr_test_pkg::word_idx_t mismatch_count,
    output ddr_test_pkg::word_idx_t resp_err_count
);
    import ddr_test_pkg::*;

    logic [MAX_DATA_WIDTH-1:0] expected;
    logic                      data_bad;
    logic                      resp_bad;
    logic                      finish;
    word_idx_t                 mis_next;
    word_idx_t                 err_next;

    assign expected = pattern_word(beats.idx, DATA_WIDTH);
    assign data_bad = beats.beat_valid && (beats.data != expected[DATA_WIDTH-1:0]);
    assign resp_bad = beats.beat_valid && (beats.resp != RESP_OKAY);
    assign finish   = beats.beat_valid && beats.last && wr_done;

    always_comb begin
        mis_next = mismatch_count + word_idx_t'(data_bad);
        err_next = resp_err_count + word_idx_t'(resp_bad);
        // write errors are folded in together with the last read beat.
        if (finish) begin
            err_next = err_next + wr_err_count;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mismatch_count <= '0;
            resp_err_count <= '0;
            test_done      <= 1'b0;
            test_pass      <= 1'b0;
        end else if (!test_done) begin
            mismatch_count <= mis_next;
            resp_err_count <= err_next;
            if (finish) begin
                test_done <= 1'b1;
                test_pass <= (mis_next == '0) && (err_next == '0);
            end
        end
    end

    // the verdict is final, so the read side must be quiet by then.
    a_no_late_beat: assert property (@(posedge clk) disable iff (!rstn)
        test_done |-> !beats.beat_valid);

endmodule

// File: logic/axi_rd_engine.sv
module axi_rd_engine #(
    parameter int                      DATA_WIDTH = 128,
    parameter int                      NUM_WORDS  = 8,
    parameter ddr_test_pkg::axi_addr_t BASE_ADDR  = 32'h4000_0000
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    ddr_ready,
    input  logic                    wr_done,
    output ddr_test_pkg::axi_addr_t araddr,
    output logic                    arvalid,
    input  logic                    arready,
    input  logic [DATA_WIDTH-1:0]   rdata,
    input  logic                    rvalid,
    input  ddr_test_pkg::axi_resp_t rresp,
    rd_beat_if.src                  beats
);
    import ddr_test_pkg::*;

    localparam axi_addr_t WORD_BYTES = axi_addr_t'(DATA_WIDTH / 8);
    localparam word_idx_t LAST_IDX   = word_idx_t'(NUM_WORDS - 1);
    localparam word_idx_t ALL_BEATS  = word_idx_t'(NUM_WORDS);

    rd_state_t state;
    word_idx_t ar_cnt;
    word_idx_t rx_cnt;
    logic      ar_fire;

    assign ar_fire = arvalid && arready;
    // ar_cnt counts accepted addresses, so it is also the index on offer.
    assign araddr  = BASE_ADDR + axi_addr_t'(ar_cnt) * WORD_BYTES;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= RD_IDLE;
            arvalid <= 1'b0;
            ar_cnt  <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (wr_done && ddr_ready) begin
                        arvalid <= 1'b1;
                        state   <= RD_ISSUE;
                    end
                end
                RD_ISSUE: begin
                    if (ar_fire) begin
                        ar_cnt <= ar_cnt + 1'b1;
                        if (ar_cnt == LAST_IDX) begin
                            arvalid <= 1'b0;
                            state   <= RD_DRAIN;
                        end
                    end
                end
                RD_DRAIN: begin
                    if (rx_cnt == ALL_BEATS) begin
                        state <= RD_DONE;
                    end
                end
                default: begin
                    arvalid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beats.beat_valid <= 1'b0;
            rx_cnt           <= '0;
        end else begin
            beats.beat_valid <= rvalid;
            if (rvalid) begin
                rx_cnt <= rx_cnt + 1'b1;
            end
        end
    end

    // beats come back in address order, so arrival order gives the index.
    always_ff @(posedge clk) begin
        if (rvalid) begin
            beats.data <= rdata;
            beats.resp <= rresp;
            beats.idx  <= rx_cnt;
            beats.last <= (rx_cnt == LAST_IDX);
        end
    end

    a_no_extra_beat: assert property (@(posedge clk) disable iff (!rstn)
        rvalid |-> rx_cnt < ar_cnt);

    a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

// File: logic/axi_wr_engine.sv
module axi_wr_engine #(
    parameter int                      DATA_WIDTH = 128,
    parameter int                      NUM_WORDS  = 8,
    parameter ddr_test_pkg::axi_addr_t BASE_ADDR  = 32'h4000_0000
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    ddr_ready,
    output ddr_test_pkg::axi_addr_t awaddr,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [DATA_WIDTH-1:0]   wdata,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    input  ddr_test_pkg::axi_resp_t bresp,
    output logic                    wr_done,
    output ddr_test_pkg::word_idx_t wr_err_count
);
    import ddr_test_pkg::*;

    localparam axi_addr_t WORD_BYTES = axi_addr_t'(DATA_WIDTH / 8);
    localparam word_idx_t LAST_IDX   = word_idx_t'(NUM_WORDS - 1);

    wr_state_t                 state;
    word_idx_t                 idx;
    logic                      aw_ok;
    logic                      w_ok;
    logic                      aw_fire;
    logic                      w_fire;
    logic [MAX_DATA_WIDTH-1:0] pattern;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign pattern = pattern_word(idx, DATA_WIDTH);
    assign awaddr  = BASE_ADDR + axi_addr_t'(idx) * WORD_BYTES;
    assign wdata   = pattern[DATA_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= WR_IDLE;
            idx          <= '0;
            awvalid      <= 1'b0;
            wvalid       <= 1'b0;
            aw_ok        <= 1'b0;
            w_ok         <= 1'b0;
            wr_done      <= 1'b0;
            wr_err_count <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (ddr_ready) begin
                        state <= WR_ISSUE;
                    end
                end
                WR_ISSUE: begin
                    if (!awvalid && !wvalid && !aw_ok && !w_ok) begin
                        // only reached once, for word 0 right after IDLE.
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end else begin
                        // the slave may take address and data in either order.
                        if (aw_fire) begin
                            awvalid <= 1'b0;
                            aw_ok   <= 1'b1;
                        end
                        if (w_fire) begin
                            wvalid <= 1'b0;
                            w_ok   <= 1'b1;
                        end
                        if ((aw_ok || aw_fire) && (w_ok || w_fire)) begin
                            aw_ok <= 1'b0;
                            w_ok  <= 1'b0;
                            state <= WR_WAIT_RESP;
                        end
                    end
                end
                WR_WAIT_RESP: begin
                    if (bvalid) begin
                        if (bresp != RESP_OKAY) begin
                            wr_err_count <= wr_err_count + 1'b1;
                        end
                        if (idx == LAST_IDX) begin
                            wr_done <= 1'b1;
                            state   <= WR_DONE;
                        end else begin
                            idx     <= idx + 1'b1;
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= WR_ISSUE;
                        end
                    end
                end
                default: begin
                    wr_done <= 1'b1;
                end
            endcase
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr));

    a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(wdata));

    // a response with no write outstanding means the slave lost track.
    a_b_in_wait: assert property (@(posedge clk) disable iff (!rstn)
        bvalid |-> state == WR_WAIT_RESP);

endmodule

// File: logic/rd_beat_if.sv
interface rd_beat_if #(
    parameter int DATA_WIDTH = 128
);
    import ddr_test_pkg::*;

    logic                  beat_valid;
    logic [DATA_WIDTH-1:0] data;
    word_idx_t             idx;
    axi_resp_t             resp;
    logic                  last;

    modport src (
        output beat_valid, data, idx, resp, last
    );

    modport snk (
        input beat_valid, data, idx, resp, last
    );

endinterface

// File: logic/ddr_test_pkg.sv
package ddr_test_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [1:0]  axi_resp_t;
    typedef logic [15:0] word_idx_t;

    // the two engines share one package, so their state names carry a prefix.
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ISSUE,
        WR_WAIT_RESP,
        WR_DONE
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        RD_DRAIN,
        RD_DONE
    } rd_state_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;
    localparam logic [31:0] PATTERN_KEY = 32'h5A3C_96E1;

    // widest data bus the pattern generator can fill.
    localparam int MAX_DATA_WIDTH = 1024;

    // each 32-bit lane holds the word index on top and the lane number below.
    function automatic logic [MAX_DATA_WIDTH-1:0] pattern_word(
        input word_idx_t   idx,
        input int unsigned width
    );
        logic [MAX_DATA_WIDTH-1:0] word;
        int j;
        word = '0;
        for (j = 0; j < MAX_DATA_WIDTH / 32; j++) begin
            if (j < int'(width / 32)) begin
                word[j*32 +: 32] = {idx, 16'(j)} ^ PATTERN_KEY;
            end
        end
        return word;
    endfunction

endpackage
